/* design/cachePkg.sv */
package cachePkg;

  // split of a 32-bit fetch address
  typedef logic [20:0] tag_t;
  typedef logic [5:0]  index_t;
  typedef logic [4:0]  offset_t;

  // one line is four 64-bit beats
  typedef logic [255:0] line_t;
  typedef logic [63:0]  word_t;

  // controller states
  typedef enum logic [2:0] {
    idle,
    lookup,
    missReq,
    refill,
    fill
  } cacheState_t;

  // top address nibble of cacheable space
  localparam logic [3:0] CACHED_REGION = 4'h8;

endpackage

/* design/busPkg.sv */
package busPkg;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] beat_t;

  // burst length field, number of beats minus one
  typedef logic [7:0] burstLen_t;

  // beats in one cache line
  localparam int LINE_BEATS = 4;

endpackage

/* design/wayRamIf.sv */
`timescale 1ns/1ps

interface wayRamIf import cachePkg::*; ();

  logic   chipEn;
  logic   wrEn;
  index_t index;
  line_t  wrLine;
  // registered read data, valid the cycle after an enabled read
  line_t  rdLine;

  modport ctrl (
    output chipEn,
    output wrEn,
    output index,
    output wrLine,
    input  rdLine
  );

  modport ram (
    input  chipEn,
    input  wrEn,
    input  index,
    input  wrLine,
    output rdLine
  );

endinterface

/* design/icacheDataRam.sv */
`timescale 1ns/1ps

module icacheDataRam import cachePkg::*; #(
  parameter int NUM_SETS = 64
) (
  input logic  clk,
  wayRamIf.ram ram
);

  // one line per set
  line_t mem [NUM_SETS];
  line_t rdReg;

  always_ff @(posedge clk) begin
    if (ram.chipEn) begin
      if (ram.wrEn) begin
        mem[ram.index] <= ram.wrLine;
      end else begin
        rdReg <= mem[ram.index];
      end
    end
  end

  // output register holds when not reading
  assign ram.rdLine = rdReg;

endmodule

/* design/icacheCtrl.sv */
`timescale 1ns/1ps

module icacheCtrl import cachePkg::*, busPkg::*; #(
  parameter int NUM_SETS = 64
) (
  input  logic      clk,
  input  logic      rst_n,
  // fetch side
  input  logic      reqValid_i,
  input  addr_t     reqAddr_i,
  output logic      addrOk_o,
  output logic      dataOk_o,
  output word_t     rdData_o,
  // refill side
  output logic      memRdValid_o,
  input  logic      memRdReady_i,
  output addr_t     memAddr_o,
  output burstLen_t memLen_o,
  input  beat_t     memData_i,
  input  logic      memDataValid_i,
  input  logic      memLast_i,
  // way data arrays
  wayRamIf.ctrl     way0,
  wayRamIf.ctrl     way1
);

  localparam int BEAT_W = $clog2(LINE_BEATS);
  localparam int WORD_W = $bits(word_t);
  localparam int OFF_W  = $bits(offset_t);
  localparam int IDX_W  = $bits(index_t);

  cacheState_t state;
  cacheState_t nextState;

  addr_t   reqLatch;
  tag_t    reqTag;
  index_t  reqIndex;
  offset_t reqOffset;
  index_t  inIndex;
  logic    uncached;

  tag_t                tagArray [2][NUM_SETS];
  logic [NUM_SETS-1:0] validArray [2];

  logic way0Hit;
  logic way1Hit;
  logic hit;
  logic accept;
  logic fillEn;
  logic lastBeat;
  logic useBuf;
  logic victim;

  logic [BEAT_W-1:0] beatCnt;
  logic [BEAT_W-1:0] wordSel;
  line_t             lineBuf;
  line_t             selLine;

  // latched request fields
  assign reqTag    = reqLatch[31 -: $bits(tag_t)];
  assign reqIndex  = reqLatch[OFF_W +: IDX_W];
  assign reqOffset = reqLatch[OFF_W-1:0];
  assign uncached  = reqLatch[31:28] != CACHED_REGION;

  // index of the incoming request, used for the parallel way read
  assign inIndex = reqAddr_i[OFF_W +: IDX_W];

  assign way0Hit = validArray[0][reqIndex] && (tagArray[0][reqIndex] == reqTag);
  assign way1Hit = validArray[1][reqIndex] && (tagArray[1][reqIndex] == reqTag);

  // buffer hit right after a fill or an uncached return
  assign hit = useBuf || (!uncached && (way0Hit || way1Hit));

  assign addrOk_o = (state == idle) || (state == lookup && hit);
  assign accept   = reqValid_i && addrOk_o;
  assign fillEn   = state == fill;
  assign lastBeat = memDataValid_i && memLast_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    unique case (state)
      idle: begin
        if (reqValid_i) begin
          nextState = lookup;
        end
      end
      lookup: begin
        if (!hit) begin
          nextState = missReq;
        end else if (!reqValid_i) begin
          nextState = idle;
        end
      end
      missReq: begin
        if (memRdReady_i) begin
          nextState = refill;
        end
      end
      refill: begin
        if (lastBeat) begin
          nextState = uncached ? lookup : fill;
        end
      end
      fill: begin
        nextState = lookup;
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqLatch <= reqAddr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      useBuf  <= 1'b0;
      beatCnt <= '0;
      victim  <= 1'b0;
    end else begin
      useBuf <= fillEn || (state == refill && lastBeat && uncached);
      if (state == refill && memDataValid_i) begin
        beatCnt <= memLast_i ? '0 : beatCnt + 1'b1;
      end
      // toggle only on cacheable refills
      if (fillEn) begin
        victim <= ~victim;
      end
    end
  end

  // collect refill beats
  always_ff @(posedge clk) begin
    if (state == refill && memDataValid_i) begin
      lineBuf[beatCnt*WORD_W +: WORD_W] <= memData_i;
    end
  end

  // tag and valid written in the fill cycle
  always_ff @(posedge clk) begin
    if (fillEn) begin
      tagArray[victim][reqIndex] <= reqTag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArray[0] <= '0;
      validArray[1] <= '0;
    end else if (fillEn) begin
      validArray[victim][reqIndex] <= 1'b1;
    end
  end

  // way arrays, read on accept and write the victim on fill
  assign way0.chipEn = accept || (fillEn && !victim);
  assign way0.wrEn   = fillEn && !victim;
  assign way0.index  = fillEn ? reqIndex : inIndex;
  assign way0.wrLine = lineBuf;

  assign way1.chipEn = accept || (fillEn && victim);
  assign way1.wrEn   = fillEn && victim;
  assign way1.index  = fillEn ? reqIndex : inIndex;
  assign way1.wrLine = lineBuf;

  // uncached word always lands in beat 0
  assign wordSel = uncached ? '0 : reqOffset[4:3];

  always_comb begin
    if (useBuf) begin
      selLine = lineBuf;
    end else if (way0Hit) begin
      selLine = way0.rdLine;
    end else begin
      selLine = way1.rdLine;
    end
  end

  assign rdData_o = selLine[wordSel*WORD_W +: WORD_W];
  assign dataOk_o = (state == lookup) && hit;

  // refill request, line aligned unless uncached
  assign memRdValid_o = state == missReq;
  assign memAddr_o    = uncached ? reqLatch : {reqTag, reqIndex, offset_t'(0)};
  assign memLen_o     = uncached ? '0 : burstLen_t'(LINE_BEATS - 1);

endmodule

/* design/fetchCache.sv */
`timescale 1ns/1ps

module fetchCache import cachePkg::*, busPkg::*; #(
  parameter int NUM_SETS = 64
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      reqValid_i,
  input  addr_t     reqAddr_i,
  output logic      addrOk_o,
  output logic      dataOk_o,
  output word_t     rdData_o,
  output logic      memRdValid_o,
  input  logic      memRdReady_i,
  output addr_t     memAddr_o,
  output burstLen_t memLen_o,
  input  beat_t     memData_i,
  input  logic      memDataValid_i,
  input  logic      memLast_i
);

  wayRamIf way0If ();
  wayRamIf way1If ();

  icacheCtrl #(
    .NUM_SETS(NUM_SETS)
  ) ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqAddr_i     (reqAddr_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .rdData_o      (rdData_o),
    .memRdValid_o  (memRdValid_o),
    .memRdReady_i  (memRdReady_i),
    .memAddr_o     (memAddr_o),
    .memLen_o      (memLen_o),
    .memData_i     (memData_i),
    .memDataValid_i(memDataValid_i),
    .memLast_i     (memLast_i),
    .way0          (way0If.ctrl),
    .way1          (way1If.ctrl)
  );

  // one line array per way
  icacheDataRam #(
    .NUM_SETS(NUM_SETS)
  ) way0Ram (
    .clk(clk),
    .ram(way0If.ram)
  );

  icacheDataRam #(
    .NUM_SETS(NUM_SETS)
  ) way1Ram (
    .clk(clk),
    .ram(way1If.ram)
  );

endmodule

/* dv/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
  parameter realtime PERIOD     = 4.0,
  parameter int      RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* dv/fetchCache_properties.sv */
`timescale 1ns/1ps

module fetchCache_properties import busPkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      memRdValid_o,
  input logic      memRdReady_i,
  input addr_t     memAddr_o,
  input burstLen_t memLen_o,
  input logic      memDataValid_i,
  input logic      memLast_i,
  input logic      dataOk_o
);

  // set at the request handshake, cleared by the last beat
  logic burstOpen;

  // number of assertion failures so far
  int failCount = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      burstOpen <= 1'b0;
    end else if (memRdValid_o && memRdReady_i) begin
      burstOpen <= 1'b1;
    end else if (memDataValid_i && memLast_i) begin
      burstOpen <= 1'b0;
    end
  end

  reqStable: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_o && !memRdReady_i |=>
      memRdValid_o && $stable(memAddr_o) && $stable(memLen_o))
    else begin
      $error("refill request changed before memRdReady_i");
      failCount++;
    end

  noDataInBurst: assert property (@(posedge clk) disable iff (!rst_n)
    (memRdValid_o || burstOpen) |-> !dataOk_o)
    else begin
      $error("dataOk_o high while a burst is outstanding");
      failCount++;
    end

  lenLegal: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_o |-> (memLen_o == 8'd0 || memLen_o == 8'd3))
    else begin
      $error("memLen_o is neither 0 nor 3");
      failCount++;
    end

endmodule

bind fetchCache fetchCache_properties props (.*);

/* dv/fetchCache_tb.sv */
`timescale 1ns/1ps

module fetchCache_tb import cachePkg::*, busPkg::*;;

  localparam int NUM_TESTS = 14;

  typedef struct {
    string name;
    addr_t addr;
    int    reqs;
    bit    stream;
  } fetchTest_t;

  logic      clk;
  logic      rst_n;
  logic      reqValid_i;
  addr_t     reqAddr_i;
  logic      addrOk_o;
  logic      dataOk_o;
  word_t     rdData_o;
  logic      memRdValid_o;
  logic      memRdReady_i;
  addr_t     memAddr_o;
  burstLen_t memLen_o;
  beat_t     memData_i;
  logic      memDataValid_i;
  logic      memLast_i;

  fetchTest_t  tests [NUM_TESTS];
  logic [15:0] lfsr = 16'd32480;
  int          memReqs = 0;
  addr_t       lastMemAddr;
  burstLen_t   lastMemLen;
  int          cycle = 0;
  int          errCount = 0;
  int          testErrs = 0;
  int          failedTests = 0;

  tbClock #(.PERIOD(4.0), .RESET_CYCLES(2)) clkGen (.clk(clk), .rst_n(rst_n));

  fetchCache #(.NUM_SETS(64)) fetchCache_i (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid_i), .reqAddr_i(reqAddr_i),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .rdData_o(rdData_o),
    .memRdValid_o(memRdValid_o), .memRdReady_i(memRdReady_i),
    .memAddr_o(memAddr_o), .memLen_o(memLen_o), .memData_i(memData_i),
    .memDataValid_i(memDataValid_i), .memLast_i(memLast_i)
  );

  // memory contents, a mix of the word address and a constant
  function automatic word_t memWord(input addr_t a);
    return {a ^ 32'h5A3C_96E1, a + 32'h0F1E_2D3C};
  endfunction

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic takeBit(output logic b);
    lfsr = lfsrNext(lfsr);
    b = lfsr[0];
  endtask

  task automatic checkValue(input string test, input string what,
                            input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("FAIL %s %s: expected %0h, actual %0h", test, what, expected, actual);
      errCount++;
      testErrs++;
    end
  endtask

  always @(posedge clk) cycle <= cycle + 1;

  // request handshake happens at the next rising edge
  always @(negedge clk) begin
    if (memRdValid_o && memRdReady_i) begin
      memReqs++;
      lastMemAddr = memAddr_o;
      lastMemLen  = memLen_o;
    end
  end

  // memory responder with random ready delay and beat gaps
  initial begin : memResponder
    logic  b0;
    logic  b1;
    logic  gap;
    addr_t base;
    int    len;
    memRdReady_i   = 1'b0;
    memDataValid_i = 1'b0;
    memLast_i      = 1'b0;
    memData_i      = '0;
    forever begin
      @(negedge clk);
      if (memRdValid_o) begin
        base = memAddr_o & ~32'h7;
        len  = memLen_o;
        takeBit(b0);
        takeBit(b1);
        repeat ({b1, b0}) @(posedge clk);
        @(posedge clk);
        memRdReady_i <= 1'b1;
        @(posedge clk);
        memRdReady_i <= 1'b0;
        for (int k = 0; k <= len; k++) begin
          takeBit(gap);
          if (gap) begin
            memDataValid_i <= 1'b0;
            @(posedge clk);
          end
          memDataValid_i <= 1'b1;
          memData_i      <= memWord(base + 8 * k);
          memLast_i      <= (k == len);
          @(posedge clk);
        end
        memDataValid_i <= 1'b0;
        memLast_i      <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_TESTS * 40) @(posedge clk);
    $display("ERROR: watchdog expired, a fetch was never accepted or answered");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : mainSeq
    int    reqBase;
    int    prevRet;
    int    propFails;
    addr_t expAddr;
    reqValid_i = 1'b0;
    reqAddr_i  = '0;
    prevRet    = 0;
    tests[0]  = '{"lineMiss",     32'h8000_0108, 1, 1'b0};
    tests[1]  = '{"hitWord0",     32'h8000_0100, 0, 1'b0};
    tests[2]  = '{"hitWord2",     32'h8000_0110, 0, 1'b1};
    tests[3]  = '{"hitWord3",     32'h8000_0118, 0, 1'b1};
    tests[4]  = '{"uncachedA",    32'h1000_0040, 1, 1'b0};
    tests[5]  = '{"uncachedB",    32'h1000_0040, 1, 1'b0};
    // victim goes way1 here, then A way0, B way1, C way0 over A
    tests[6]  = '{"otherLine",    32'h8000_0200, 1, 1'b0};
    tests[7]  = '{"setTagA",      32'h8000_00A0, 1, 1'b0};
    // an uncached fetch between A and B must leave the victim bit alone
    tests[8]  = '{"uncachedC",    32'h1000_0040, 1, 1'b0};
    tests[9]  = '{"setTagB",      32'h8001_00A8, 1, 1'b0};
    tests[10] = '{"setTagC",      32'h8002_00B0, 1, 1'b0};
    tests[11] = '{"refetchB",     32'h8001_00B8, 0, 1'b0};
    tests[12] = '{"refetchA",     32'h8000_00A0, 1, 1'b0};
    tests[13] = '{"hitAfterEvict", 32'h8000_00A8, 0, 1'b0};

    wait (rst_n);
    @(negedge clk);
    checkValue("reset", "addrOk_o", 1, addrOk_o);
    checkValue("reset", "dataOk_o", 0, dataOk_o);
    checkValue("reset", "memRdValid_o", 0, memRdValid_o);

    for (int i = 0; i < NUM_TESTS; i++) begin
      testErrs = 0;
      if (!tests[i].stream) begin
        @(posedge clk);
        reqValid_i <= 1'b1;
        reqAddr_i  <= tests[i].addr;
        @(negedge clk);
      end
      while (!addrOk_o) @(negedge clk);
      @(posedge clk);
      reqBase = memReqs;
      // a streamed successor goes out in the acceptance cycle
      if (i + 1 < NUM_TESTS && tests[i + 1].stream) begin
        reqAddr_i <= tests[i + 1].addr;
      end else begin
        reqValid_i <= 1'b0;
      end
      do @(negedge clk); while (!dataOk_o);

      checkValue(tests[i].name, "data", memWord(tests[i].addr & ~32'h7), rdData_o);
      checkValue(tests[i].name, "requests", tests[i].reqs, memReqs - reqBase);
      if (tests[i].reqs == 1 && memReqs - reqBase == 1) begin
        if (tests[i].addr[31:28] == 4'h8) begin
          expAddr = tests[i].addr & ~32'h1F;
          checkValue(tests[i].name, "memLen_o", 3, lastMemLen);
        end else begin
          expAddr = tests[i].addr;
          checkValue(tests[i].name, "memLen_o", 0, lastMemLen);
        end
        checkValue(tests[i].name, "memAddr_o", expAddr, lastMemAddr);
      end
      if (tests[i].stream) begin
        checkValue(tests[i].name, "return cycle", prevRet + 1, cycle);
      end
      prevRet = cycle;

      if (testErrs == 0) begin
        $display("PASS %s", tests[i].name);
      end else begin
        $display("test %s finished with %0d errors", tests[i].name, testErrs);
        failedTests++;
      end
    end

    propFails = fetchCache_i.props.failCount;
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             NUM_TESTS, failedTests, errCount, propFails);
    if (errCount == 0 && propFails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* fetchCache.f */
design/cachePkg.sv
design/busPkg.sv
design/wayRamIf.sv
design/icacheDataRam.sv
design/icacheCtrl.sv
design/fetchCache.sv
dv/tbClock.sv
dv/fetchCache_properties.sv
dv/fetchCache_tb.sv
